//--- build.f
design/ram_model_pkg.sv
design/ram_storage.sv
design/burst_addr_gen.sv
design/ram_timing_model.sv
design/ram_model_top.sv
tests/ram_model_sva.sv
tests/ram_model_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ram_model_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/ram_model_tb.sv
`timescale 1ns/1ps

module ram_model_tb import ram_model_pkg::*; ();

    typedef struct packed {
        bit                    is_write;
        logic [addr_width-1:0] addr;
        int                    len;
        burst_t                burst;
        int                    nstall;
        int                    nhold;
    } txn_t;

    localparam int num_txn = 8;

    logic                  clk;
    logic                  resetn;
    logic                  arvalid;
    logic                  arready;
    logic [addr_width-1:0] araddr;
    logic [len_width-1:0]  arlen;
    burst_t                arburst;
    logic                  rvalid;
    logic                  rready;
    logic [data_width-1:0] rdata;
    logic                  rlast;
    logic                  awvalid;
    logic                  awready;
    logic [addr_width-1:0] awaddr;
    burst_t                awburst;
    logic                  wvalid;
    logic                  wready;
    logic [data_width-1:0] wdata;
    logic                  wlast;
    logic                  bvalid;
    logic                  bready;
    logic                  stall;

    txn_t                  txns [num_txn];
    logic [data_width-1:0] ref_mem [mem_words];
    int                    checks = 0;
    int                    errors = 0;
    int                    cycles = 0;
    int                    cycle_limit = 1000;

    ram_model_top dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [data_width-1:0] exp,
                             input logic [data_width-1:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // incr steps one word and wraps with the index width, fixed stays put.
    function automatic logic [index_width-1:0] next_index(input logic [index_width-1:0] idx,
                                                          input burst_t burst);
        if (burst == burst_fixed) begin
            return idx;
        end
        return idx + 1'b1;
    endfunction

    task automatic run_write(input txn_t t);
        logic [index_width-1:0] idx;
        logic                   fire;
        int                     lat;
        awaddr = t.addr;
        awburst = t.burst;
        awvalid = 1'b1;
        fire = 1'b0;
        while (!fire) begin
            fire = awready && !stall;
            @(negedge clk);
        end
        awvalid = 1'b0;
        check_bit("awready", 1'b0, awready);
        idx = t.addr[index_width+1:2];
        for (int b = 0; b <= t.len; b++) begin
            wdata = $urandom();
            wlast = (b == t.len);
            wvalid = 1'b1;
            fire = 1'b0;
            while (!fire) begin
                fire = wready && !stall;
                @(negedge clk);
            end
            ref_mem[idx] = wdata;
            idx = next_index(idx, t.burst);
        end
        wvalid = 1'b0;
        wlast = 1'b0;
        check_bit("wready", 1'b0, wready);
        // stall covers the first nstall edges after the wlast transfer.
        lat = 0;
        while (!bvalid) begin
            stall = (lat < t.nstall);
            @(negedge clk);
            lat++;
        end
        stall = 1'b0;
        check_val("write response latency", w_delay + t.nstall, lat);
        repeat (t.nhold) begin
            @(negedge clk);
            check_bit("bvalid", 1'b1, bvalid);
        end
        // a stalled edge does not take the response.
        if (t.nstall > 0) begin
            stall = 1'b1;
            bready = 1'b1;
            @(negedge clk);
            stall = 1'b0;
            check_bit("bvalid", 1'b1, bvalid);
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        check_bit("bvalid", 1'b0, bvalid);
        check_bit("awready", 1'b1, awready);
        check_bit("wready", 1'b1, wready);
    endtask

    task automatic run_read(input txn_t t);
        logic [index_width-1:0] idx;
        logic                   fire;
        int                     lat;
        araddr = t.addr;
        arlen = len_width'(t.len);
        arburst = t.burst;
        arvalid = 1'b1;
        fire = 1'b0;
        while (!fire) begin
            fire = arready && !stall;
            @(negedge clk);
        end
        arvalid = 1'b0;
        check_bit("arready", 1'b0, arready);
        lat = 0;
        while (!rvalid) begin
            stall = (lat < t.nstall);
            @(negedge clk);
            lat++;
        end
        stall = 1'b0;
        check_val("read latency", r_delay + t.nstall, lat);
        // the first beat stays on the bus until it is taken.
        idx = t.addr[index_width+1:2];
        repeat (t.nhold) begin
            @(negedge clk);
            check_bit("rvalid", 1'b1, rvalid);
            check_val("rdata", ref_mem[idx], rdata);
            check_bit("rlast", t.len == 0, rlast);
        end
        // a stalled edge takes no beat.
        if (t.nstall > 0) begin
            stall = 1'b1;
            rready = 1'b1;
            @(negedge clk);
            stall = 1'b0;
            check_bit("rvalid", 1'b1, rvalid);
            check_val("rdata", ref_mem[idx], rdata);
            check_bit("rlast", t.len == 0, rlast);
        end
        // with rready high the beats must follow on consecutive cycles.
        rready = 1'b1;
        for (int b = 0; b <= t.len; b++) begin
            check_bit("rvalid", 1'b1, rvalid);
            check_val("rdata", ref_mem[idx], rdata);
            check_bit("rlast", b == t.len, rlast);
            @(negedge clk);
            idx = next_index(idx, t.burst);
        end
        rready = 1'b0;
        check_bit("rvalid", 1'b0, rvalid);
        check_bit("arready", 1'b1, arready);
    endtask

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        arlen = '0;
        arburst = burst_incr;
        rready = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        awburst = burst_incr;
        wvalid = 1'b0;
        wdata = '0;
        wlast = 1'b0;
        bready = 1'b0;
        stall = 1'b0;
        void'($urandom(3637));

        // is_write, address, len, burst, stall cycles, hold cycles.
        txns[0] = '{1'b1, 32'h0000_0040, 3, burst_incr, 0, 0};
        txns[1] = '{1'b0, 32'h0000_0040, 3, burst_incr, 0, 0};
        txns[2] = '{1'b1, 32'h0000_0100, 2, burst_fixed, 0, 2};
        txns[3] = '{1'b0, 32'h0000_0100, 3, burst_fixed, 0, 0};
        txns[4] = '{1'b1, 32'h0000_03f8, 3, burst_incr, 4, 0};
        txns[5] = '{1'b0, 32'h0000_03f8, 3, burst_incr, 5, 3};
        txns[6] = '{1'b1, 32'h0000_0080, 0, burst_incr, 2, 1};
        txns[7] = '{1'b0, 32'h0000_0080, 0, burst_incr, 0, 4};

        cycle_limit = 40;
        for (int i = 0; i < num_txn; i++) begin
            cycle_limit += txns[i].len + 1 + r_delay + w_delay + txns[i].nstall
                + txns[i].nhold + 12;
        end

        repeat (5) @(negedge clk);
        resetn = 1'b1;
        check_bit("arready", 1'b1, arready);
        check_bit("awready", 1'b1, awready);
        check_bit("wready", 1'b1, wready);
        check_bit("rvalid", 1'b0, rvalid);
        check_bit("rlast", 1'b0, rlast);
        check_bit("bvalid", 1'b0, bvalid);

        for (int i = 0; i < num_txn; i++) begin
            if (txns[i].is_write) begin
                run_write(txns[i]);
            end else begin
                run_read(txns[i]);
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tests/ram_model_sva.sv
`timescale 1ns/1ps

module ram_model_sva import ram_model_pkg::*; (
    input logic                  clk,
    input logic                  resetn,
    input logic                  rvalid,
    input logic                  rready,
    input logic                  rlast,
    input logic [data_width-1:0] rdata,
    input logic                  bvalid,
    input logic                  bready,
    input logic                  stall
);

    // a read beat that was not taken stays on the bus unchanged.
    read_beat_held: assert property (
        @(posedge clk) disable iff (!resetn)
        rvalid && (!rready || stall) |=> rvalid && $stable(rdata) && $stable(rlast)
    ) else $error("read beat changed before its transfer");

    write_resp_held: assert property (
        @(posedge clk) disable iff (!resetn)
        bvalid && (!bready || stall) |=> bvalid
    ) else $error("write response dropped before its transfer");

    rlast_with_rvalid: assert property (
        @(posedge clk) disable iff (!resetn)
        rlast |-> rvalid
    ) else $error("rlast high without rvalid");

endmodule

bind ram_model_top ram_model_sva sva (
    .clk    (clk),
    .resetn (resetn),
    .rvalid (rvalid),
    .rready (rready),
    .rlast  (rlast),
    .rdata  (rdata),
    .bvalid (bvalid),
    .bready (bready),
    .stall  (stall)
);

//--- design/ram_model_top.sv
`timescale 1ns/1ps

module ram_model_top import ram_model_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,

    input  logic                  arvalid,
    output logic                  arready,
    input  logic [addr_width-1:0] araddr,
    input  logic [len_width-1:0]  arlen,
    input  burst_t                arburst,

    output logic                  rvalid,
    input  logic                  rready,
    output logic [data_width-1:0] rdata,
    output logic                  rlast,

    input  logic                  awvalid,
    output logic                  awready,
    input  logic [addr_width-1:0] awaddr,
    input  burst_t                awburst,

    input  logic                  wvalid,
    output logic                  wready,
    input  logic [data_width-1:0] wdata,
    input  logic                  wlast,

    output logic                  bvalid,
    input  logic                  bready,

    input  logic                  stall
);

    logic                   rd_start;
    logic                   rd_beat;
    logic                   wr_start;
    logic                   wr_beat;
    logic [index_width-1:0] rd_index;
    logic [index_width-1:0] wr_index;

    ram_timing_model timing (
        .clk      (clk),
        .resetn   (resetn),
        .arvalid  (arvalid),
        .arready  (arready),
        .arlen    (arlen),
        .rvalid   (rvalid),
        .rready   (rready),
        .rlast    (rlast),
        .awvalid  (awvalid),
        .awready  (awready),
        .wvalid   (wvalid),
        .wready   (wready),
        .wlast    (wlast),
        .bvalid   (bvalid),
        .bready   (bready),
        .stall    (stall),
        .rd_start (rd_start),
        .rd_beat  (rd_beat),
        .wr_start (wr_start),
        .wr_beat  (wr_beat)
    );

    burst_addr_gen rd_addr (
        .clk    (clk),
        .resetn (resetn),
        .start  (rd_start),
        .addr   (araddr),
        .burst  (arburst),
        .step   (rd_beat),
        .index  (rd_index)
    );

    burst_addr_gen wr_addr (
        .clk    (clk),
        .resetn (resetn),
        .start  (wr_start),
        .addr   (awaddr),
        .burst  (awburst),
        .step   (wr_beat),
        .index  (wr_index)
    );

    ram_storage storage (
        .clk      (clk),
        .rd_index (rd_index),
        .wr_en    (wr_beat),
        .wr_index (wr_index),
        .wdata    (wdata),
        .rdata    (rdata)
    );

endmodule

//--- design/ram_timing_model.sv
`timescale 1ns/1ps

module ram_timing_model import ram_model_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,

    input  logic                 arvalid,
    output logic                 arready,
    input  logic [len_width-1:0] arlen,

    output logic                 rvalid,
    input  logic                 rready,
    output logic                 rlast,

    input  logic                 awvalid,
    output logic                 awready,

    input  logic                 wvalid,
    output logic                 wready,
    input  logic                 wlast,

    output logic                 bvalid,
    input  logic                 bready,

    input  logic                 stall,

    output logic                 rd_start,
    output logic                 rd_beat,
    output logic                 wr_start,
    output logic                 wr_beat
);

    logic                   rd_open;
    logic [len_width-1:0]   rd_left;
    logic [delay_width-1:0] rd_cnt;

    logic                   aw_held;
    logic                   w_done;
    logic [delay_width-1:0] wr_cnt;

    logic                   b_done;

    // qualified transfer strobes. nothing moves on a stalled edge.
    assign rd_start = arvalid && arready && !stall;
    assign rd_beat  = rvalid && rready && !stall;
    assign wr_start = awvalid && awready && !stall;
    assign wr_beat  = wvalid && wready && !stall;
    assign b_done   = bvalid && bready && !stall;

    assign arready = !rd_open;
    assign rvalid  = rd_open && (rd_cnt == '0);
    assign rlast   = rvalid && (rd_left == '0);

    assign awready = !aw_held;
    assign wready  = !w_done;
    assign bvalid  = aw_held && w_done && (wr_cnt == '0);

    // a read burst stays open from the address transfer until its last beat.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_open <= 1'b0;
        end else if (rd_start) begin
            rd_open <= 1'b1;
        end else if (rd_beat && rd_left == '0) begin
            rd_open <= 1'b0;
        end
    end

    // beats still to send after the current one.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_left <= '0;
        end else if (rd_start) begin
            rd_left <= arlen;
        end else if (rd_beat) begin
            rd_left <= rd_left - 1'b1;
        end
    end

    // the first beat waits r_delay unstalled cycles; later beats stream.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_cnt <= '0;
        end else if (!stall) begin
            if (rd_start) begin
                rd_cnt <= delay_width'(r_delay);
            end else if (rd_cnt != '0) begin
                rd_cnt <= rd_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            aw_held <= 1'b0;
        end else if (wr_start) begin
            aw_held <= 1'b1;
        end else if (b_done) begin
            aw_held <= 1'b0;
        end
    end

    // set by the wlast beat, so wready drops until the response is taken.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            w_done <= 1'b0;
        end else if (wr_beat && wlast) begin
            w_done <= 1'b1;
        end else if (b_done) begin
            w_done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_cnt <= '0;
        end else if (!stall) begin
            if (wr_beat && wlast) begin
                wr_cnt <= delay_width'(w_delay);
            end else if (wr_cnt != '0) begin
                wr_cnt <= wr_cnt - 1'b1;
            end
        end
    end

endmodule

//--- design/burst_addr_gen.sv
`timescale 1ns/1ps

module burst_addr_gen import ram_model_pkg::*; (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    input  logic [addr_width-1:0]  addr,
    input  burst_t                 burst,
    input  logic                   step,
    output logic [index_width-1:0] index
);

    logic [index_width-1:0] index_q;
    logic [index_width-1:0] load_index;
    logic                   fixed_q;
    logic                   fixed_now;

    // byte address to word index; the low two bits are always zero.
    assign load_index = addr[index_width+1:2];

    // the loaded address is visible in the start cycle itself, so a beat
    // accepted on the same edge as its address lands in the right word.
    assign index     = start ? load_index : index_q;
    assign fixed_now = start ? (burst == burst_fixed) : fixed_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fixed_q <= 1'b0;
        end else if (start) begin
            fixed_q <= (burst == burst_fixed);
        end
    end

    // the index is index_width bits wide, so it wraps at mem_words.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            index_q <= '0;
        end else if (step && !fixed_now) begin
            index_q <= index + 1'b1;
        end else if (start) begin
            index_q <= load_index;
        end
    end

endmodule

//--- design/ram_storage.sv
`timescale 1ns/1ps

module ram_storage import ram_model_pkg::*; (
    input  logic                   clk,
    input  logic [index_width-1:0] rd_index,
    input  logic                   wr_en,
    input  logic [index_width-1:0] wr_index,
    input  logic [data_width-1:0]  wdata,
    output logic [data_width-1:0]  rdata
);

    logic [data_width-1:0] mem [mem_words];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wdata;
        end
    end

    // combinational read, so rdata follows the read index in the same cycle.
    assign rdata = mem[rd_index];

endmodule

//--- design/ram_model_pkg.sv
package ram_model_pkg;

    // byte address and data word widths; every beat moves one full word.
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // the store holds mem_words words, so the word index needs index_width bits.
    localparam int mem_words = 256;
    localparam int index_width = $clog2(mem_words);

    // burst length field, beats minus one.
    localparam int len_width = 8;

    // cycles from read address acceptance to the first beat, and from
    // the last write beat to the write response.
    localparam int r_delay = 6;
    localparam int w_delay = 3;
    localparam int delay_width = 4;

    // 2'b10 is the wrap encoding; it is not modelled and steps like incr.
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01
    } burst_t;

endpackage
